// ==== rtl/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and address width of the integer datapath
`define CORE_XLEN 32

`define CORE_NREGS 32 // register 0 reads as zero

// queue entries, also the credit count the sender starts with
`define CORE_IQ_DEPTH 4

`endif

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  localparam opcode_t OP_R     = 7'b0110011;
  localparam opcode_t OP_IMM   = 7'b0010011;
  localparam opcode_t OP_AUIPC = 7'b0010111;

  localparam funct3_t F3_ADD  = 3'b000; // also SUB and MUL
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101; // SRL or SRA, picked by funct7
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // selects SUB and SRA
  localparam funct7_t F7_ALT = 7'b0100000;
  localparam funct7_t F7_MUL = 7'b0000001;

endpackage : isa_pkg

// ==== rtl/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] data_t;
  typedef logic [`CORE_XLEN-1:0] addr_t;

  // index into the architectural register file
  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

  typedef logic [4:0] shamt_t;

endpackage : core_pkg

// ==== rtl/instr_queue.sv ====
`include "core_config.svh"

module instr_queue (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            instr_valid_i,
  input  isa_pkg::instr_t instr_i,
  input  core_pkg::addr_t pc_i,
  input  logic            pop_i,
  output logic            head_valid_o,
  output isa_pkg::instr_t head_instr_o,
  output core_pkg::addr_t head_pc_o,
  output logic            credit_o
);

  localparam int PTR_W = $clog2(`CORE_IQ_DEPTH);
  localparam int CNT_W = $clog2(`CORE_IQ_DEPTH + 1);

  isa_pkg::instr_t  instr_mem [`CORE_IQ_DEPTH];
  core_pkg::addr_t  pc_mem    [`CORE_IQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  assign head_valid_o = count_q != '0;
  assign do_pop       = pop_i && head_valid_o;
  assign head_instr_o = instr_mem[rd_ptr_q];
  assign head_pc_o    = pc_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (instr_valid_i) // a push always has a free slot behind it
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`CORE_IQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`CORE_IQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q  <= count_q + CNT_W'(instr_valid_i) - CNT_W'(do_pop);
      credit_o <= do_pop; // one credit back per entry that left
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      instr_mem[wr_ptr_q] <= instr_i;
      pc_mem[wr_ptr_q]    <= pc_i;
    end
  end

endmodule : instr_queue

// ==== rtl/issue_ctrl.sv ====
module issue_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               head_valid_i,
  input  logic               is_mul_i,
  input  logic               reads_rs1_i,
  input  logic               reads_rs2_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  core_pkg::reg_idx_t rd_i,
  output logic               issue_o
);

  // multiply stages whose result cannot be bypassed yet, ex1 to ex4
  localparam int MUL_PEND = 4;

  logic               alu_v_q;
  core_pkg::reg_idx_t alu_rd_q;
  logic [MUL_PEND-1:0] ex_v_q;
  core_pkg::reg_idx_t ex_rd_q [MUL_PEND];

  logic raw_stall;
  logic waw_stall;
  logic slot_stall;

  always_comb begin
    logic rs1_busy;
    logic rs2_busy;
    logic rd_busy;

    rs1_busy = alu_v_q && (alu_rd_q == rs1_i);
    rs2_busy = alu_v_q && (alu_rd_q == rs2_i);
    rd_busy  = alu_v_q && (alu_rd_q == rd_i);
    for (int i = 0; i < MUL_PEND; i++) begin
      rs1_busy = rs1_busy || (ex_v_q[i] && (ex_rd_q[i] == rs1_i));
      rs2_busy = rs2_busy || (ex_v_q[i] && (ex_rd_q[i] == rs2_i));
      rd_busy  = rd_busy  || (ex_v_q[i] && (ex_rd_q[i] == rd_i));
    end

    // register 0 never has a real writer
    raw_stall = (reads_rs1_i && rs1_busy && (rs1_i != '0)) ||
                (reads_rs2_i && rs2_busy && (rs2_i != '0));
    waw_stall = rd_busy && (rd_i != '0);

    // an ALU op issued now reaches writeback on the same edge as the ex4 multiply
    slot_stall = !is_mul_i && ex_v_q[MUL_PEND-1];
  end

  assign issue_o = head_valid_i && !(raw_stall || waw_stall || slot_stall);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_v_q <= 1'b0;
      ex_v_q  <= '0;
    end else begin
      alu_v_q <= issue_o && !is_mul_i;
      ex_v_q  <= {ex_v_q[MUL_PEND-2:0], issue_o && is_mul_i};
    end
  end

  // the rd shadows only count when the matching valid bit is set
  always_ff @(posedge clk_i) begin
    alu_rd_q   <= rd_i;
    ex_rd_q[0] <= rd_i;
    for (int i = 1; i < MUL_PEND; i++) begin
      ex_rd_q[i] <= ex_rd_q[i-1];
    end
  end

endmodule : issue_ctrl

// ==== rtl/decode_stage.sv ====
module decode_stage (
  input  logic               valid_i,
  input  isa_pkg::instr_t    instruction_i,
  input  core_pkg::addr_t    pc_i,
  input  core_pkg::data_t    rs1_data_i,
  input  core_pkg::data_t    rs2_data_i,
  input  logic               ex5_valid_i,
  input  core_pkg::reg_idx_t ex5_wr_reg_i,
  input  core_pkg::data_t    ex5_result_i,
  input  logic               wb_reg_wr_en_i,
  input  core_pkg::reg_idx_t wb_wr_reg_i,
  input  core_pkg::data_t    wb_data_to_reg_i,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  output core_pkg::reg_idx_t rd_o,
  output logic               reads_rs1_o,
  output logic               reads_rs2_o,
  output logic               is_mul_o,
  output logic               alu_valid_o,
  output logic               ex_valid_o,
  output core_pkg::shamt_t   shamt_o,
  output core_pkg::data_t    offset_sign_extend_o,
  output core_pkg::addr_t    alu_pc_o,
  output core_pkg::data_t    alu_rs1_data_o,
  output core_pkg::data_t    alu_rs2_data_o,
  output isa_pkg::funct3_t   funct3_o,
  output isa_pkg::funct7_t   funct7_o,
  output isa_pkg::opcode_t   opcode_o
);

  assign opcode_o = instruction_i[6:0];
  assign rd_o     = instruction_i[11:7];
  assign funct3_o = instruction_i[14:12];
  assign rs1_o    = instruction_i[19:15];
  assign rs2_o    = instruction_i[24:20];
  assign funct7_o = instruction_i[31:25];

  assign reads_rs1_o = opcode_o != isa_pkg::OP_AUIPC;
  assign reads_rs2_o = opcode_o == isa_pkg::OP_R; // immediate forms use the offset instead

  assign is_mul_o = (opcode_o == isa_pkg::OP_R) && (funct3_o == isa_pkg::F3_ADD) &&
                    (funct7_o == isa_pkg::F7_MUL);

  assign alu_valid_o = valid_i && !is_mul_o;
  assign ex_valid_o  = valid_i && is_mul_o;
  assign alu_pc_o    = pc_i;

  // only the immediate shifts take their amount from the instruction
  assign shamt_o = (opcode_o == isa_pkg::OP_IMM) ? instruction_i[24:20] : '0;

  always_comb begin
    case (opcode_o)
      isa_pkg::OP_IMM:
        offset_sign_extend_o = core_pkg::data_t'($signed(instruction_i[31:20]));
      isa_pkg::OP_AUIPC:
        offset_sign_extend_o = core_pkg::data_t'($signed({instruction_i[31:12], 12'b0}));
      default:
        offset_sign_extend_o = '0;
    endcase
  end

  // ex5 holds the younger value when both it and writeback match
  always_comb begin
    logic ex5_rs1;
    logic ex5_rs2;
    logic wb_rs1;
    logic wb_rs2;

    ex5_rs1 = reads_rs1_o && ex5_valid_i && (rs1_o == ex5_wr_reg_i) && (rs1_o != '0);
    ex5_rs2 = reads_rs2_o && ex5_valid_i && (rs2_o == ex5_wr_reg_i) && (rs2_o != '0);
    wb_rs1  = reads_rs1_o && wb_reg_wr_en_i && (rs1_o == wb_wr_reg_i) && (rs1_o != '0);
    wb_rs2  = reads_rs2_o && wb_reg_wr_en_i && (rs2_o == wb_wr_reg_i) && (rs2_o != '0);

    if (ex5_rs1) alu_rs1_data_o = ex5_result_i;
    else if (wb_rs1) alu_rs1_data_o = wb_data_to_reg_i;
    else alu_rs1_data_o = rs1_data_i;

    if (ex5_rs2) alu_rs2_data_o = ex5_result_i;
    else if (wb_rs2) alu_rs2_data_o = wb_data_to_reg_i;
    else alu_rs2_data_o = rs2_data_i;
  end

endmodule : decode_stage

// ==== rtl/alu_stage.sv ====
module alu_stage (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  isa_pkg::opcode_t   opcode_i,
  input  isa_pkg::funct3_t   funct3_i,
  input  isa_pkg::funct7_t   funct7_i,
  input  core_pkg::addr_t    pc_i,
  input  core_pkg::data_t    rs1_data_i,
  input  core_pkg::data_t    rs2_data_i,
  input  core_pkg::data_t    offset_i,
  input  core_pkg::shamt_t   shamt_i,
  input  core_pkg::reg_idx_t rd_i,
  output logic               valid_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::data_t    result_o
);

  isa_pkg::opcode_t opcode_q;
  isa_pkg::funct3_t funct3_q;
  isa_pkg::funct7_t funct7_q;
  core_pkg::addr_t  pc_q;
  core_pkg::data_t  op_a_q;
  core_pkg::data_t  rs2_q;
  core_pkg::data_t  offset_q;
  core_pkg::shamt_t shamt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) valid_o <= 1'b0;
    else valid_o <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    opcode_q <= opcode_i;
    funct3_q <= funct3_i;
    funct7_q <= funct7_i;
    pc_q     <= pc_i;
    op_a_q   <= rs1_data_i;
    rs2_q    <= rs2_data_i;
    offset_q <= offset_i;
    shamt_q  <= shamt_i;
    rd_o     <= rd_i;
  end

  always_comb begin
    logic             is_imm;
    core_pkg::data_t  op_b;
    core_pkg::shamt_t sh;

    is_imm = opcode_q == isa_pkg::OP_IMM;
    op_b   = is_imm ? offset_q : rs2_q;
    sh     = is_imm ? shamt_q : rs2_q[4:0];

    if (opcode_q == isa_pkg::OP_AUIPC) begin
      result_o = pc_q + offset_q;
    end else begin
      case (funct3_q)
        isa_pkg::F3_ADD: begin
          // ADDI has immediate bits in the funct7 field, so SUB needs the R form
          if (!is_imm && (funct7_q == isa_pkg::F7_ALT)) result_o = op_a_q - op_b;
          else result_o = op_a_q + op_b;
        end
        isa_pkg::F3_SLL:  result_o = op_a_q << sh;
        isa_pkg::F3_SLT:  result_o = core_pkg::data_t'($signed(op_a_q) < $signed(op_b));
        isa_pkg::F3_SLTU: result_o = core_pkg::data_t'(op_a_q < op_b);
        isa_pkg::F3_XOR:  result_o = op_a_q ^ op_b;
        isa_pkg::F3_SR: begin
          if (funct7_q == isa_pkg::F7_ALT) result_o = $signed(op_a_q) >>> sh;
          else result_o = op_a_q >> sh;
        end
        isa_pkg::F3_OR:   result_o = op_a_q | op_b;
        default:          result_o = op_a_q & op_b;
      endcase
    end
  end

endmodule : alu_stage

// ==== rtl/mul_pipe.sv ====
module mul_pipe (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::data_t    rs1_data_i,
  input  core_pkg::data_t    rs2_data_i,
  output logic               ex5_valid_o,
  output core_pkg::reg_idx_t ex5_rd_o,
  output core_pkg::data_t    ex5_result_o
);

  localparam int STAGES = 5;

  logic [STAGES-1:0]  vld_q; // bit 0 is ex1
  core_pkg::reg_idx_t rd_q [STAGES];
  core_pkg::data_t    op_a_q;
  core_pkg::data_t    op_b_q;

  // product registers for ex2 to ex5
  core_pkg::data_t    prod_q [STAGES-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) vld_q <= '0;
    else vld_q <= {vld_q[STAGES-2:0], valid_i};
  end

  always_ff @(posedge clk_i) begin
    op_a_q    <= rs1_data_i;
    op_b_q    <= rs2_data_i;
    rd_q[0]   <= rd_i;
    prod_q[0] <= op_a_q * op_b_q; // low half only
    for (int i = 1; i < STAGES; i++) begin
      rd_q[i] <= rd_q[i-1];
    end
    for (int i = 1; i < STAGES - 1; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign ex5_valid_o  = vld_q[STAGES-1];
  assign ex5_rd_o     = rd_q[STAGES-1];
  assign ex5_result_o = prod_q[STAGES-2];

endmodule : mul_pipe

// ==== rtl/regfile_wb.sv ====
`include "core_config.svh"

module regfile_wb (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  logic               alu_valid_i,
  input  core_pkg::reg_idx_t alu_rd_i,
  input  core_pkg::data_t    alu_result_i,
  input  logic               ex5_valid_i,
  input  core_pkg::reg_idx_t ex5_rd_i,
  input  core_pkg::data_t    ex5_result_i,
  output core_pkg::data_t    rs1_data_o,
  output core_pkg::data_t    rs2_data_o,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_rd_o,
  output core_pkg::data_t    wb_data_o
);

  core_pkg::data_t rf_q [`CORE_NREGS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) wb_valid_o <= 1'b0;
    else wb_valid_o <= alu_valid_i || ex5_valid_i;
  end

  // issue control keeps both lanes from arriving together, ex5 wins regardless
  always_ff @(posedge clk_i) begin
    wb_rd_o   <= ex5_valid_i ? ex5_rd_i : alu_rd_i;
    wb_data_o <= ex5_valid_i ? ex5_result_i : alu_result_i;
    if (wb_valid_o && (wb_rd_o != '0))
      rf_q[wb_rd_o] <= wb_data_o;
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : rf_q[rs1_i]; // entry 0 is never written
  assign rs2_data_o = (rs2_i == '0) ? '0 : rf_q[rs2_i];

endmodule : regfile_wb

// ==== rtl/core_top.sv ====
module core_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  isa_pkg::instr_t    instr_i,
  input  core_pkg::addr_t    pc_i,
  output logic               credit_o,
  output logic               retire_valid_o,
  output core_pkg::reg_idx_t retire_rd_o,
  output core_pkg::data_t    retire_data_o
);

  logic               head_valid;
  isa_pkg::instr_t    head_instr;
  core_pkg::addr_t    head_pc;
  logic               issue;
  logic               is_mul;
  logic               reads_rs1;
  logic               reads_rs2;
  core_pkg::reg_idx_t rs1;
  core_pkg::reg_idx_t rs2;
  core_pkg::reg_idx_t rd;
  core_pkg::data_t    rs1_data;
  core_pkg::data_t    rs2_data;
  logic               alu_valid;
  logic               ex_valid;
  core_pkg::shamt_t   shamt;
  core_pkg::data_t    offset;
  core_pkg::addr_t    alu_pc;
  core_pkg::data_t    op_a;
  core_pkg::data_t    op_b;
  isa_pkg::funct3_t   funct3;
  isa_pkg::funct7_t   funct7;
  isa_pkg::opcode_t   opcode;
  logic               alu_out_valid;
  core_pkg::reg_idx_t alu_out_rd;
  core_pkg::data_t    alu_result;
  logic               ex5_valid;
  core_pkg::reg_idx_t ex5_rd;
  core_pkg::data_t    ex5_result;

  instr_queue i_instr_queue (
    .clk_i, .rst_n_i, .instr_valid_i, .instr_i, .pc_i, .pop_i(issue),
    .head_valid_o(head_valid), .head_instr_o(head_instr), .head_pc_o(head_pc), .credit_o
  );

  issue_ctrl i_issue_ctrl (
    .clk_i, .rst_n_i, .head_valid_i(head_valid), .is_mul_i(is_mul),
    .reads_rs1_i(reads_rs1), .reads_rs2_i(reads_rs2),
    .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .issue_o(issue)
  );

  // writeback feeds the bypass and the retire port alike
  decode_stage i_decode_stage (
    .valid_i(issue), .instruction_i(head_instr), .pc_i(head_pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex5_valid_i(ex5_valid), .ex5_wr_reg_i(ex5_rd), .ex5_result_i(ex5_result),
    .wb_reg_wr_en_i(retire_valid_o), .wb_wr_reg_i(retire_rd_o),
    .wb_data_to_reg_i(retire_data_o),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
    .reads_rs1_o(reads_rs1), .reads_rs2_o(reads_rs2), .is_mul_o(is_mul),
    .alu_valid_o(alu_valid), .ex_valid_o(ex_valid),
    .shamt_o(shamt), .offset_sign_extend_o(offset), .alu_pc_o(alu_pc),
    .alu_rs1_data_o(op_a), .alu_rs2_data_o(op_b),
    .funct3_o(funct3), .funct7_o(funct7), .opcode_o(opcode)
  );

  alu_stage i_alu_stage (
    .clk_i, .rst_n_i, .valid_i(alu_valid), .opcode_i(opcode), .funct3_i(funct3),
    .funct7_i(funct7), .pc_i(alu_pc), .rs1_data_i(op_a), .rs2_data_i(op_b),
    .offset_i(offset), .shamt_i(shamt), .rd_i(rd),
    .valid_o(alu_out_valid), .rd_o(alu_out_rd), .result_o(alu_result)
  );

  mul_pipe i_mul_pipe (
    .clk_i, .rst_n_i, .valid_i(ex_valid), .rd_i(rd), .rs1_data_i(op_a), .rs2_data_i(op_b),
    .ex5_valid_o(ex5_valid), .ex5_rd_o(ex5_rd), .ex5_result_o(ex5_result)
  );

  regfile_wb i_regfile_wb (
    .clk_i, .rst_n_i, .rs1_i(rs1), .rs2_i(rs2),
    .alu_valid_i(alu_out_valid), .alu_rd_i(alu_out_rd), .alu_result_i(alu_result),
    .ex5_valid_i(ex5_valid), .ex5_rd_i(ex5_rd), .ex5_result_i(ex5_result),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .wb_valid_o(retire_valid_o), .wb_rd_o(retire_rd_o), .wb_data_o(retire_data_o)
  );

endmodule : core_top

// ==== verif/tb_core.sv ====
`include "core_config.svh"

module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_PRE = `CORE_NREGS - 1;
  localparam int N_MIX = 40;
  localparam int N_DEP = 40;
  localparam int N_INTER = 60;
  localparam int CYCLE_LIMIT = 40 * (N_PRE + N_MIX + N_DEP + N_INTER) + 200;

  localparam int CLS_R = 0;
  localparam int CLS_IMM = 1;
  localparam int CLS_AUIPC = 2;
  localparam int CLS_MUL = 3;

  logic               clk_i;
  logic               rst_n_i;
  logic               instr_valid_i;
  isa_pkg::instr_t    instr_i;
  core_pkg::addr_t    pc_i;
  logic               credit_o;
  logic               retire_valid_o;
  core_pkg::reg_idx_t retire_rd_o;
  core_pkg::data_t    retire_data_o;

  logic [31:0]     rng_state;
  core_pkg::addr_t next_pc;
  core_pkg::data_t model_rf [`CORE_NREGS] = '{default: '0};
  core_pkg::data_t exp_data [`CORE_NREGS] = '{default: '0};
  int issued_cnt [`CORE_NREGS] = '{default: 0}; // written by the driver only
  int retired_cnt [`CORE_NREGS] = '{default: 0}; // written by the monitor only
  int sent = 0;
  int issued_total = 0;
  int errors = 0;
  int checks = 0;
  int returned = 0;
  int retired_total = 0;
  int mon_errors = 0;
  int mon_checks = 0;
  int cycles;

  core_top i_core_top (
    .clk_i, .rst_n_i, .instr_valid_i, .instr_i, .pc_i,
    .credit_o, .retire_valid_o, .retire_rd_o, .retire_data_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function logic [31:0] rand32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  function int below(input int n);
    return int'(rand32() % 32'(n));
  endfunction

  function automatic logic is_pending(input int r);
    return issued_cnt[r] != retired_cnt[r];
  endfunction

  function int free_rd();
    int r;
    r = 1 + below(31);
    while (is_pending(r)) r = 1 + below(31);
    return r;
  endfunction

  function int ready_reg();
    int r;
    r = below(32);
    while (is_pending(r)) r = below(32); // x0 is never pending
    return r;
  endfunction

  function automatic int all_errors();
    return errors + mon_errors;
  endfunction

  function automatic int all_checks();
    return checks + mon_checks;
  endfunction

  // op index: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
  function automatic isa_pkg::funct3_t op_f3(input int op);
    case (op)
      0, 1: return isa_pkg::F3_ADD;
      2: return isa_pkg::F3_SLL;
      3: return isa_pkg::F3_SLT;
      4: return isa_pkg::F3_SLTU;
      5: return isa_pkg::F3_XOR;
      6, 7: return isa_pkg::F3_SR;
      8: return isa_pkg::F3_OR;
      default: return isa_pkg::F3_AND;
    endcase
  endfunction

  function automatic core_pkg::data_t ref_result(input int op, input core_pkg::data_t a,
                                                 input core_pkg::data_t b);
    case (op)
      0: return a + b;
      1: return a - b;
      2: return a << b[4:0];
      3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4: return (a < b) ? 32'd1 : 32'd0;
      5: return a ^ b;
      6: return a >> b[4:0];
      7: return core_pkg::data_t'($signed(a) >>> b[4:0]);
      8: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic send_word(input isa_pkg::instr_t w);
    @(posedge clk_i);
    while ((sent - returned) >= `CORE_IQ_DEPTH) begin // out of credits
      instr_valid_i <= 1'b0;
      @(posedge clk_i);
    end
    instr_valid_i <= 1'b1;
    instr_i <= w;
    pc_i <= next_pc;
    next_pc = next_pc + 32'd4;
    sent++;
  endtask

  task automatic idle();
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
  endtask

  task automatic run_op(input int cls, input int op, input int rd, input int rs1, input int rs2);
    core_pkg::data_t  a;
    core_pkg::data_t  b;
    core_pkg::data_t  res;
    logic [11:0]      imm;
    logic [19:0]      upper;
    isa_pkg::funct7_t f7;
    isa_pkg::instr_t  w;

    a = model_rf[rs1];
    b = model_rf[rs2];
    f7 = (op == 1 || op == 7) ? isa_pkg::F7_ALT : 7'b0;
    imm = 12'(rand32());
    upper = 20'(rand32());
    case (cls)
      CLS_R: begin
        w = {f7, 5'(rs2), 5'(rs1), op_f3(op), 5'(rd), isa_pkg::OP_R};
        res = ref_result(op, a, b);
      end
      CLS_IMM: begin
        if (op == 2 || op == 6 || op == 7) imm = {f7, imm[4:0]}; // shifts keep funct7 on top
        w = {imm, 5'(rs1), op_f3(op), 5'(rd), isa_pkg::OP_IMM};
        res = ref_result(op, a, core_pkg::data_t'($signed(imm)));
      end
      CLS_AUIPC: begin
        w = {upper, 5'(rd), isa_pkg::OP_AUIPC};
        res = next_pc + {upper, 12'b0};
      end
      default: begin
        w = {isa_pkg::F7_MUL, 5'(rs2), 5'(rs1), isa_pkg::F3_ADD, 5'(rd), isa_pkg::OP_R};
        res = a * b;
      end
    endcase
    model_rf[rd] = res; // program order, so later readers see this value
    exp_data[rd] = res;
    issued_cnt[rd]++;
    issued_total++;
    send_word(w);
  endtask

  task automatic drain();
    while (issued_total != retired_total) @(posedge clk_i);
  endtask

  task automatic check_idle();
    checks += 2;
    if (credit_o !== 1'b0) begin
      errors++;
      $display("error t=%0t credit_o: got %b expected 0", $time, credit_o);
    end
    if (retire_valid_o !== 1'b0) begin
      errors++;
      $display("error t=%0t retire_valid_o: got %b expected 0", $time, retire_valid_o);
    end
  endtask

  task automatic report_test(input string name, input int err0, input int chk0);
    $display("test %s: %0d checks, %0d errors", name, all_checks() - chk0,
             all_errors() - err0);
  endtask

  // retire and credit outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (credit_o === 1'b1) begin
        returned++;
        if (returned > sent) begin
          mon_errors++;
          $display("a credit came back at %0t with no instruction outstanding", $time);
        end
      end
      if (retire_valid_o === 1'b1) begin
        mon_checks++;
        if (!is_pending(int'(retire_rd_o))) begin
          mon_errors++;
          $display("x%0d retired at %0t but no write to it was outstanding", retire_rd_o,
                   $time);
        end else begin
          if (retire_data_o !== exp_data[retire_rd_o]) begin
            mon_errors++;
            $display("error t=%0t retire_data_o: got %h expected %h for x%0d", $time,
                     retire_data_o, exp_data[retire_rd_o], retire_rd_o);
          end
          retired_cnt[retire_rd_o]++;
          retired_total++;
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int cls;
    int op;
    int rd;
    int last;
    int e0;
    int c0;

    rng_state = 32'd47554;
    next_pc = '0;
    rst_n_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;

    e0 = all_errors();
    c0 = all_checks();
    repeat (3) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    rst_n_i <= 1'b1; // fourth rising edge
    repeat (3) begin
      @(negedge clk_i);
      check_idle();
    end
    report_test("reset state", e0, c0);

    e0 = all_errors();
    c0 = all_checks();
    for (int r = 1; r < `CORE_NREGS; r++) run_op(CLS_IMM, 0, r, 0, 0);
    for (int i = 0; i < N_MIX; i++) begin
      cls = below(2);
      op = below(10);
      if (cls == CLS_IMM && op == 1) op = 0; // there is no SUBI
      run_op(cls, op, free_rd(), ready_reg(), ready_reg());
    end
    idle();
    drain();
    report_test("independent alu mix", e0, c0);

    e0 = all_errors();
    c0 = all_checks();
    last = 1;
    for (int i = 0; i < N_DEP; i++) begin
      cls = below(4);
      op = below(10);
      if (cls == CLS_IMM && op == 1) op = 0;
      rd = free_rd();
      run_op(cls, op, rd, last, (below(2) == 0) ? last : below(32));
      last = rd;
    end
    idle();
    drain();
    report_test("dependent chains", e0, c0);

    e0 = all_errors();
    c0 = all_checks();
    for (int i = 0; i < N_INTER; i++) begin
      op = below(8);
      cls = (op < 3) ? CLS_MUL : (op < 6) ? CLS_R : (op == 6) ? CLS_IMM : CLS_AUIPC;
      op = below(10);
      if (cls == CLS_IMM && op == 1) op = 0;
      run_op(cls, op, free_rd(), below(32), below(32));
    end
    idle();
    drain();
    report_test("mul and alu interleave", e0, c0);

    e0 = all_errors();
    c0 = all_checks();
    repeat (2) @(posedge clk_i);
    checks++;
    if (returned != sent) begin
      errors++;
      $display("%0d instructions were sent but %0d credits came back", sent, returned);
    end
    report_test("credit accounting", e0, c0);

    $display("tests 5, checks %0d, errors %0d", all_checks(), all_errors());
    if (all_errors() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_core

// ==== vlog.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/instr_queue.sv
rtl/issue_ctrl.sv
rtl/decode_stage.sv
rtl/alu_stage.sv
rtl/mul_pipe.sv
rtl/regfile_wb.sv
rtl/core_top.sv
verif/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build tb_core with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 -f vlog.f --top-module tb_core \
  -Mdir obj_dir -o tb_core_sim \
  && ./obj_dir/tb_core_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
